//--- la_pkg.sv
////////////////////////////////////////////////////////////
// shared types of the logic analyzer capture path
// widths below are the defaults, module parameters must agree
// single 8-bit sample lane, all structs are packed
////////////////////////////////////////////////////////////

package la_pkg;

  // default widths, matching the top level parameters
  localparam int unsigned DW  = 8;
  localparam int unsigned CW  = 32;
  localparam int unsigned DCW = 17;
  localparam int unsigned TN  = 4;
  localparam int unsigned TW  = 64;

  typedef logic [DW-1:0] la_data_t;

  ////////////////////////////////////////////////////////////
  // stream beats
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    la_data_t data;
    logic     last;
  } la_smp_t;

  // count is zero in bypass mode
  typedef struct packed {
    logic [7:0] count;
    la_data_t   data;
    logic       last;
  } la_rle_t;

  ////////////////////////////////////////////////////////////
  // register bus
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic        wen;
    logic        ren;
    logic [6:0]  addr;
    logic [31:0] wdata;
  } la_bus_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        ack;
  } la_bus_rsp_t;

  // register map, byte offsets
  typedef enum logic [6:0] {
    reg_ctl        = 7'h00,
    reg_mode       = 7'h04,
    reg_trg_sel    = 7'h08,
    reg_pre        = 7'h10,
    reg_pst        = 7'h14,
    reg_sts_pre    = 7'h18,
    reg_sts_pst    = 7'h1c,
    reg_cts_acq_lo = 7'h20,
    reg_cts_acq_hi = 7'h24,
    reg_cts_trg_lo = 7'h28,
    reg_cts_trg_hi = 7'h2c,
    reg_cts_stp_lo = 7'h30,
    reg_cts_stp_hi = 7'h34,
    reg_cmp_msk    = 7'h40,
    reg_cmp_val    = 7'h44,
    reg_edg_pos    = 7'h48,
    reg_edg_neg    = 7'h4c,
    reg_dec        = 7'h50,
    reg_rle        = 7'h54
  } la_reg_e;

  typedef enum logic [1:0] {
    acq_idle,
    acq_pre,
    acq_armed,
    acq_post
  } la_acq_state_e;

  ////////////////////////////////////////////////////////////
  // configuration, control pulses, status
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic           con;
    logic           aut;
    logic [TN-1:0]  trg;
    logic [CW-1:0]  pre;
    logic [CW-1:0]  pst;
    la_data_t       cmp_msk;
    la_data_t       cmp_val;
    la_data_t       edg_pos;
    la_data_t       edg_neg;
    logic [DCW-1:0] dec;
    logic           rle;
  } la_cfg_t;

  // one cycle pulses from a ctl write
  typedef struct packed {
    logic rst;
    logic acq;
    logic stp;
    logic swt;
  } la_ctl_t;

  typedef struct packed {
    logic          acq;
    logic          trg;
    logic [CW-1:0] sts_pre;
    logic [CW-1:0] sts_pst;
    logic [TW-1:0] cts_acq;
    logic [TW-1:0] cts_trg;
    logic [TW-1:0] cts_stp;
  } la_sts_t;

endpackage

//--- la_regs.sv
////////////////////////////////////////////////////////////
// register bank on the strobe bus
// ack one cycle after wen or ren, no error response
// rdata holds the register value seen at the request
// unmapped offsets, 0x58 and 0x5c included, read zero
////////////////////////////////////////////////////////////

module la_regs #(
  parameter int unsigned CW  = 32,
  parameter int unsigned DCW = 17,
  parameter int unsigned TN  = 4,
  parameter int unsigned TW  = 64
) (
  input  logic                bus,
  input  logic                reset,
  input  la_pkg::la_bus_req_t req,
  input  la_pkg::la_sts_t     sts,
  output la_pkg::la_bus_rsp_t rsp,
  output la_pkg::la_cfg_t     cfg,
  output la_pkg::la_ctl_t     ctl
);

  logic        wr_ctl;
  logic [31:0] rd_data;

  assign wr_ctl = req.wen && (req.addr == la_pkg::reg_ctl);

  ////////////////////////////////////////////////////////////
  // write decode
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (reset) begin
      cfg <= '0;
    end else if (req.wen) begin
      case (req.addr)
        la_pkg::reg_mode: begin
          cfg.con <= req.wdata[0];
          cfg.aut <= req.wdata[1];
        end
        la_pkg::reg_trg_sel: cfg.trg     <= req.wdata[TN-1:0];
        la_pkg::reg_pre:     cfg.pre     <= req.wdata[CW-1:0];
        la_pkg::reg_pst:     cfg.pst     <= req.wdata[CW-1:0];
        la_pkg::reg_cmp_msk: cfg.cmp_msk <= req.wdata[la_pkg::DW-1:0];
        la_pkg::reg_cmp_val: cfg.cmp_val <= req.wdata[la_pkg::DW-1:0];
        la_pkg::reg_edg_pos: cfg.edg_pos <= req.wdata[la_pkg::DW-1:0];
        la_pkg::reg_edg_neg: cfg.edg_neg <= req.wdata[la_pkg::DW-1:0];
        la_pkg::reg_dec:     cfg.dec     <= req.wdata[DCW-1:0];
        la_pkg::reg_rle:     cfg.rle     <= req.wdata[0];
        default: ;
      endcase
    end
  end

  // ctl bits become pulses, aligned with ack
  always_ff @(posedge bus) begin
    if (reset) begin
      ctl <= '0;
    end else begin
      ctl.rst <= wr_ctl && req.wdata[0];
      ctl.swt <= wr_ctl && req.wdata[1];
      ctl.acq <= wr_ctl && req.wdata[2];
      ctl.stp <= wr_ctl && req.wdata[3];
    end
  end

  ////////////////////////////////////////////////////////////
  // read mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (req.addr)
      // status view of ctl
      la_pkg::reg_ctl:        rd_data = {28'd0, ~sts.acq, sts.acq, sts.trg, 1'b0};
      la_pkg::reg_mode:       rd_data = {30'd0, cfg.aut, cfg.con};
      la_pkg::reg_trg_sel:    rd_data = 32'(cfg.trg);
      la_pkg::reg_pre:        rd_data = 32'(cfg.pre);
      la_pkg::reg_pst:        rd_data = 32'(cfg.pst);
      la_pkg::reg_sts_pre:    rd_data = 32'(sts.sts_pre[CW-1:0]);
      la_pkg::reg_sts_pst:    rd_data = 32'(sts.sts_pst[CW-1:0]);
      // timestamps as low/high halves
      la_pkg::reg_cts_acq_lo: rd_data = sts.cts_acq[31:0];
      la_pkg::reg_cts_acq_hi: rd_data = 32'(sts.cts_acq[TW-1:32]);
      la_pkg::reg_cts_trg_lo: rd_data = sts.cts_trg[31:0];
      la_pkg::reg_cts_trg_hi: rd_data = 32'(sts.cts_trg[TW-1:32]);
      la_pkg::reg_cts_stp_lo: rd_data = sts.cts_stp[31:0];
      la_pkg::reg_cts_stp_hi: rd_data = 32'(sts.cts_stp[TW-1:32]);
      // trigger detector setup
      la_pkg::reg_cmp_msk:    rd_data = 32'(cfg.cmp_msk);
      la_pkg::reg_cmp_val:    rd_data = 32'(cfg.cmp_val);
      la_pkg::reg_edg_pos:    rd_data = 32'(cfg.edg_pos);
      la_pkg::reg_edg_neg:    rd_data = 32'(cfg.edg_neg);
      la_pkg::reg_dec:        rd_data = 32'(cfg.dec);
      la_pkg::reg_rle:        rd_data = {31'd0, cfg.rle};
      default:                rd_data = '0;
    endcase
  end

  // response, rdata only loads on reads
  always_ff @(posedge bus) begin
    if (req.ren) begin
      rsp.rdata <= rd_data;
    end
    if (reset) begin
      rsp.ack <= 1'b0;
    end else begin
      rsp.ack <= req.wen || req.ren;
    end
  end

endmodule

//--- str_dec.sv
////////////////////////////////////////////////////////////
// stream decimator, forwards one beat in every dec+1
// combinational path, dropped beats are still acked
////////////////////////////////////////////////////////////

module str_dec #(
  parameter int unsigned DCW = 17
) (
  input  logic            bus,
  input  logic            reset,
  input  logic            clr,
  input  logic [DCW-1:0]  dec,
  input  la_pkg::la_smp_t in,
  input  logic            in_valid,
  output logic            in_ready,
  output la_pkg::la_smp_t out,
  output logic            out_valid,
  input  logic            out_ready
);

  // beats left to drop before the next pass
  logic [DCW-1:0] cnt;
  logic           pass;

  assign pass = (cnt == '0);

  assign out       = in;
  assign out_valid = in_valid && pass;
  // dropping never waits on the sink
  assign in_ready  = pass ? out_ready : 1'b1;

  always_ff @(posedge bus) begin
    if (reset || clr) begin
      cnt <= '0;
    end else if (in_valid && pass && out_ready) begin
      // forwarded beat, reload
      cnt <= dec;
    end else if (in_valid && !pass) begin
      cnt <= cnt - DCW'(1);
    end
  end

endmodule

//--- la_trigger.sv
////////////////////////////////////////////////////////////
// comparator and edge trigger on a monitored stream link
// trg_out pulses one cycle after a matching transfer
// first sample after clr is compared against zero history
////////////////////////////////////////////////////////////

module la_trigger (
  input  logic            bus,
  input  logic            reset,
  input  logic            clr,
  input  la_pkg::la_cfg_t cfg,
  input  la_pkg::la_smp_t smp,
  input  logic            smp_valid,
  input  logic            smp_ready,
  output logic            trg_out
);

  // previous sample and output pulse in one register
  struct packed {
    la_pkg::la_data_t prv;
    logic             trg;
  } hst;

  logic             xfer;
  la_pkg::la_data_t rise;
  la_pkg::la_data_t fall;
  logic             cmp_hit;
  logic             edg_ena;
  logic             edg_hit;

  assign xfer = smp_valid && smp_ready;

  // per bit edges against the last transfer
  assign rise = ~hst.prv & smp.data;
  assign fall = hst.prv & ~smp.data;

  assign cmp_hit = ((smp.data ^ cfg.cmp_val) & cfg.cmp_msk) == '0;
  // no edge bits selected means comparator only
  assign edg_ena = |(cfg.edg_pos | cfg.edg_neg);
  assign edg_hit = |(rise & cfg.edg_pos) || |(fall & cfg.edg_neg);

  always_ff @(posedge bus) begin
    if (reset || clr) begin
      hst <= '0;
    end else begin
      hst.trg <= xfer && cmp_hit && (!edg_ena || edg_hit);
      if (xfer) begin
        hst.prv <= smp.data;
      end
    end
  end

  assign trg_out = hst.trg;

endmodule

//--- la_acq.sv
////////////////////////////////////////////////////////////
// acquisition FSM with pre/post counters and timestamps
// beats pass combinationally outside idle, idle drops them
// trigger sources are swt, trg_out and trg_ext, bit 0 upward
////////////////////////////////////////////////////////////

module la_acq #(
  parameter int unsigned CW = 32,
  parameter int unsigned TN = 4,
  parameter int unsigned TW = 64
) (
  input  logic            bus,
  input  logic            reset,
  input  la_pkg::la_ctl_t ctl,
  input  la_pkg::la_cfg_t cfg,
  input  logic [TW-1:0]   cts,
  input  logic            trg_out,
  input  logic [TN-3:0]   trg_ext,
  input  la_pkg::la_smp_t in,
  input  logic            in_valid,
  output logic            in_ready,
  output la_pkg::la_smp_t out,
  output logic            out_valid,
  input  logic            out_ready,
  output la_pkg::la_sts_t sts,
  output logic            irq_trg,
  output logic            irq_stp
);

  la_pkg::la_acq_state_e state;

  logic [TN-1:0] trg_vec;
  logic          trg_hit;
  logic          fwd;
  logic          pst_lst;
  logic          pst_end;
  logic          go_acq;
  logic          go_trg;
  logic          go_stp;
  logic [CW-1:0] cnt_pre;
  logic [CW-1:0] cnt_pst;
  logic          trg_seen;
  logic [TW-1:0] ts_acq;
  logic [TW-1:0] ts_trg;
  logic [TW-1:0] ts_stp;

  assign trg_vec = {trg_ext, trg_out, ctl.swt};
  assign trg_hit = |(trg_vec & cfg.trg);

  ////////////////////////////////////////////////////////////
  // stream pass-through
  ////////////////////////////////////////////////////////////

  assign out_valid = (state != la_pkg::acq_idle) && in_valid;
  assign in_ready  = (state == la_pkg::acq_idle) || out_ready;
  assign fwd       = out_valid && out_ready;

  // last does not depend on ready, keeps the beat stable
  assign pst_lst = (state == la_pkg::acq_post) && !cfg.con &&
                   ((cnt_pst + CW'(1)) == cfg.pst);
  assign pst_end = fwd && pst_lst;

  assign out = '{data: in.data, last: pst_lst};

  // state events, stp wins over everything but rst
  assign go_acq = ctl.acq && !ctl.stp && (state == la_pkg::acq_idle);
  assign go_trg = !ctl.stp && (state == la_pkg::acq_armed) && (trg_hit || cfg.aut);
  assign go_stp = (ctl.stp && (state != la_pkg::acq_idle)) || pst_end;

  ////////////////////////////////////////////////////////////
  // FSM and counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (reset || ctl.rst) begin
      state    <= la_pkg::acq_idle;
      cnt_pre  <= '0;
      cnt_pst  <= '0;
      trg_seen <= 1'b0;
      irq_trg  <= 1'b0;
      irq_stp  <= 1'b0;
    end else begin
      irq_trg <= go_trg;
      irq_stp <= go_stp;
      if (go_stp) begin
        state <= la_pkg::acq_idle;
        // a beat leaving in the closing cycle still counts
        if ((state == la_pkg::acq_post) && fwd) begin
          cnt_pst <= cnt_pst + CW'(1);
        end
      end else if (go_acq) begin
        state    <= la_pkg::acq_pre;
        cnt_pre  <= '0;
        cnt_pst  <= '0;
        trg_seen <= 1'b0;
      end else if (go_trg) begin
        state    <= la_pkg::acq_post;
        trg_seen <= 1'b1;
      end else if (state == la_pkg::acq_pre) begin
        // count stops once the pre length is met
        if (cnt_pre == cfg.pre) begin
          state <= la_pkg::acq_armed;
        end else if (fwd && (cnt_pre != '1)) begin
          cnt_pre <= cnt_pre + CW'(1);
        end
      end else if ((state == la_pkg::acq_post) && fwd) begin
        cnt_pst <= cnt_pst + CW'(1);
      end
    end
  end

  // event timestamps
  always_ff @(posedge bus) begin
    if (go_acq) begin
      ts_acq <= cts;
    end
    if (go_trg) begin
      ts_trg <= cts;
    end
    if (go_stp) begin
      ts_stp <= cts;
    end
  end

  assign sts = '{
    acq:     (state != la_pkg::acq_idle),
    trg:     trg_seen,
    sts_pre: cnt_pre,
    sts_pst: cnt_pst,
    cts_acq: ts_acq,
    cts_trg: ts_trg,
    cts_stp: ts_stp
  };

endmodule

//--- la_rle.sv
////////////////////////////////////////////////////////////
// run-length encoder with a single output register
// ena low is bypass, count zero and one cycle of latency
// runs close on a value change, at 255, or on last
////////////////////////////////////////////////////////////

module la_rle (
  input  logic            bus,
  input  logic            reset,
  input  logic            clr,
  input  logic            ena,
  input  la_pkg::la_smp_t in,
  input  logic            in_valid,
  output logic            in_ready,
  output la_pkg::la_rle_t out,
  output logic            out_valid,
  input  logic            out_ready
);

  logic             out_free;
  logic             chg;
  logic             hold;
  logic             acc;
  logic             flush;
  // open run
  logic [7:0]       run_cnt;
  la_pkg::la_data_t run_dat;
  logic             run_vld;

  assign out_free = !out_valid || out_ready;
  assign chg      = run_vld && (in.data != run_dat);
  // a last beat with a new value waits one cycle for the old run to leave
  assign hold     = ena && chg && in.last;
  assign in_ready = out_free && !(in_valid && hold);
  assign acc      = in_valid && in_ready;
  assign flush    = in_valid && out_free && hold;

  always_ff @(posedge bus) begin
    if (reset || clr) begin
      out_valid <= 1'b0;
      run_vld   <= 1'b0;
    end else begin
      if (out_ready) begin
        out_valid <= 1'b0;
      end
      if (flush) begin
        out       <= '{count: run_cnt, data: run_dat, last: 1'b0};
        out_valid <= 1'b1;
        run_vld   <= 1'b0;
      end else if (acc && !ena) begin
        // bypass
        out       <= '{count: 8'd0, data: in.data, last: in.last};
        out_valid <= 1'b1;
      end else if (acc && chg) begin
        // value changed, old run out, new run opens
        out       <= '{count: run_cnt, data: run_dat, last: 1'b0};
        out_valid <= 1'b1;
        run_cnt   <= 8'd1;
        run_dat   <= in.data;
      end else if (acc && !run_vld) begin
        if (in.last) begin
          out       <= '{count: 8'd1, data: in.data, last: 1'b1};
          out_valid <= 1'b1;
        end else begin
          run_vld <= 1'b1;
          run_cnt <= 8'd1;
          run_dat <= in.data;
        end
      end else if (acc) begin
        // same value, closes at 255 or on last
        if (in.last || (run_cnt == 8'd254)) begin
          out       <= '{count: run_cnt + 8'd1, data: run_dat, last: in.last};
          out_valid <= 1'b1;
          run_vld   <= 1'b0;
        end else begin
          run_cnt <= run_cnt + 8'd1;
        end
      end
    end
  end

endmodule

//--- la_top.sv
////////////////////////////////////////////////////////////
// logic analyzer capture path, one clock and one reset
// input -> decimator -> acquisition -> encoder -> output
// parameters must agree with the la_pkg defaults
////////////////////////////////////////////////////////////

module la_top #(
  parameter int unsigned CW  = 32,
  parameter int unsigned DCW = 17,
  parameter int unsigned TN  = 4,
  parameter int unsigned TW  = 64
) (
  input  logic                bus,
  input  logic                reset,
  input  la_pkg::la_bus_req_t req,
  output la_pkg::la_bus_rsp_t rsp,
  input  logic [TW-1:0]       cts,
  input  logic [TN-3:0]       trg_ext,
  input  la_pkg::la_smp_t     in,
  input  logic                in_valid,
  output logic                in_ready,
  output la_pkg::la_rle_t     out,
  output logic                out_valid,
  input  logic                out_ready,
  output logic                trg_out,
  output logic                irq_trg,
  output logic                irq_stp
);

  la_pkg::la_cfg_t cfg;
  la_pkg::la_ctl_t ctl;
  la_pkg::la_sts_t sts;

  // decimator to acquisition, watched by the trigger
  la_pkg::la_smp_t dec_smp;
  logic            dec_valid;
  logic            dec_ready;

  // acquisition to encoder
  la_pkg::la_smp_t acq_smp;
  logic            acq_valid;
  logic            acq_ready;

  la_regs #(.CW(CW), .DCW(DCW), .TN(TN), .TW(TW)) u_regs (
    .bus(bus), .reset(reset), .req(req), .sts(sts),
    .rsp(rsp), .cfg(cfg), .ctl(ctl)
  );

  // decimation phase restarts with each acquisition
  str_dec #(.DCW(DCW)) u_dec (
    .bus(bus), .reset(reset), .clr(ctl.rst || ctl.acq), .dec(cfg.dec),
    .in(in), .in_valid(in_valid), .in_ready(in_ready),
    .out(dec_smp), .out_valid(dec_valid), .out_ready(dec_ready)
  );

  la_trigger u_trigger (
    .bus(bus), .reset(reset), .clr(ctl.rst), .cfg(cfg),
    .smp(dec_smp), .smp_valid(dec_valid), .smp_ready(dec_ready),
    .trg_out(trg_out)
  );

  la_acq #(.CW(CW), .TN(TN), .TW(TW)) u_acq (
    .bus(bus), .reset(reset), .ctl(ctl), .cfg(cfg), .cts(cts),
    .trg_out(trg_out), .trg_ext(trg_ext),
    .in(dec_smp), .in_valid(dec_valid), .in_ready(dec_ready),
    .out(acq_smp), .out_valid(acq_valid), .out_ready(acq_ready),
    .sts(sts), .irq_trg(irq_trg), .irq_stp(irq_stp)
  );

  la_rle u_rle (
    .bus(bus), .reset(reset), .clr(ctl.rst), .ena(cfg.rle),
    .in(acq_smp), .in_valid(acq_valid), .in_ready(acq_ready),
    .out(out), .out_valid(out_valid), .out_ready(out_ready)
  );

endmodule

//--- la_assert.sv
////////////////////////////////////////////////////////////
// protocol checks bound to la_top
// disabled while reset is high
////////////////////////////////////////////////////////////

module la_assert (
  input logic                bus,
  input logic                reset,
  input la_pkg::la_bus_req_t req,
  input la_pkg::la_bus_rsp_t rsp,
  input la_pkg::la_rle_t     out,
  input logic                out_valid,
  input logic                out_ready,
  input logic                irq_trg,
  input logic                irq_stp
);

  timeunit 1ns;
  timeprecision 100ps;

  // output beat held under back-pressure
  out_hold: assert property (@(posedge bus) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out))
    else $error("output beat changed while stalled");

  // one cycle bus response
  bus_ack: assert property (@(posedge bus) disable iff (reset)
    req.wen || req.ren |=> rsp.ack)
    else $error("ack missing one cycle after request");

  irq_trg_pulse: assert property (@(posedge bus) disable iff (reset)
    irq_trg |=> !irq_trg)
    else $error("irq_trg high for two cycles");

  irq_stp_pulse: assert property (@(posedge bus) disable iff (reset)
    irq_stp |=> !irq_stp)
    else $error("irq_stp high for two cycles");

endmodule

bind la_top la_assert u_assert (.*);

//--- tb_la.sv
////////////////////////////////////////////////////////////
// testbench for la_top, bus tasks and stream driver
// inputs driven 1 ns after the rising edge, outputs at negedge
////////////////////////////////////////////////////////////

module tb_la;

  timeunit 1ns;
  timeprecision 100ps;

  logic                bus;
  logic                reset;
  la_pkg::la_bus_req_t req;
  la_pkg::la_bus_rsp_t rsp;
  logic [63:0]         cts;
  logic [1:0]          trg_ext;
  la_pkg::la_smp_t     in;
  logic                in_valid;
  logic                in_ready;
  la_pkg::la_rle_t     out;
  logic                out_valid;
  logic                out_ready;
  logic                trg_out;
  logic                irq_trg;
  logic                irq_stp;

  int mism;
  int touts;
  bit stall_en;
  int trg_cnt;
  int irqs_cnt;
  int trg_mark;
  bit irq_seen;
  la_pkg::la_rle_t  got_q[$];
  la_pkg::la_rle_t  exp_q[$];
  la_pkg::la_data_t src_q[$];
  bit               src_last_q[$];

  la_top DUT (
    .bus(bus), .reset(reset), .req(req), .rsp(rsp), .cts(cts), .trg_ext(trg_ext),
    .in(in), .in_valid(in_valid), .in_ready(in_ready),
    .out(out), .out_valid(out_valid), .out_ready(out_ready),
    .trg_out(trg_out), .irq_trg(irq_trg), .irq_stp(irq_stp)
  );

  initial begin
    bus = 1'b0;
    forever #20 bus = ~bus;
  end

  // free-running timestamp and random output stalls
  always @(posedge bus) begin
    #1;
    cts = cts + 64'd1;
    out_ready = stall_en ? (($urandom % 4) != 0) : 1'b1;
  end

  // output monitor and pulse counters
  always @(negedge bus) begin
    if (!reset) begin
      if (out_valid && out_ready) got_q.push_back(out);
      if (trg_out) trg_cnt++;
      if (irq_trg) begin
        irq_seen = 1'b1;
        trg_mark = got_q.size();
      end
      if (irq_stp) irqs_cnt++;
    end
  end

  ////////////////////////////////////////////////////////////
  // reporting and compare tasks
  ////////////////////////////////////////////////////////////

  task automatic timed_out(input string what);
    touts++;
    $display("timeout at %0t: %s", $time, what);
  endtask

  task automatic cmp_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      mism++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic cmp_beat(input la_pkg::la_rle_t got, input la_pkg::la_rle_t exp,
                          input string what);
    if (got !== exp) begin
      mism++;
      $display("mismatch at %0t: %s got cnt %0d data %h last %b, expected cnt %0d data %h last %b",
               $time, what, got.count, got.data, got.last, exp.count, exp.data, exp.last);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // bus access, callers sit 1 ns after a rising edge
  ////////////////////////////////////////////////////////////

  task automatic wait_ack(output logic [31:0] rd);
    int i;
    for (i = 0; i < 20; i++) begin
      @(posedge bus);
      #1;
      req.wen = 1'b0;
      req.ren = 1'b0;
      if (rsp.ack) break;
    end
    if (i == 20) timed_out("no bus ack");
    rd = rsp.rdata;
  endtask

  task automatic bus_write(input logic [6:0] a, input logic [31:0] d);
    logic [31:0] rd;
    req = '{wen: 1'b1, ren: 1'b0, addr: a, wdata: d};
    wait_ack(rd);
  endtask

  task automatic bus_read(input logic [6:0] a, output logic [31:0] d);
    req = '{wen: 1'b0, ren: 1'b1, addr: a, wdata: 32'd0};
    wait_ack(d);
  endtask

  task automatic setup(input int mode, input int trg, input int pre, input int pst,
                       input int dec, input int rle);
    bus_write(la_pkg::reg_mode, mode);
    bus_write(la_pkg::reg_trg_sel, trg);
    bus_write(la_pkg::reg_pre, pre);
    bus_write(la_pkg::reg_pst, pst);
    bus_write(la_pkg::reg_dec, dec);
    bus_write(la_pkg::reg_rle, rle);
    // ctl rst clears FSM, trigger history and encoder
    bus_write(la_pkg::reg_ctl, 32'h1);
    got_q.delete();
    irq_seen = 1'b0;
    irqs_cnt = 0;
  endtask

  ////////////////////////////////////////////////////////////
  // stream driver and waits
  ////////////////////////////////////////////////////////////

  task automatic drive_all();
    int i;
    int t;
    for (i = 0; i < src_q.size(); i++) begin
      in = '{data: src_q[i], last: src_last_q[i]};
      in_valid = 1'b1;
      for (t = 0; t < 200; t++) begin
        @(negedge bus);
        if (in_ready) break;
      end
      if (t == 200) timed_out("input beat not accepted");
      @(posedge bus);
      #1;
    end
    in_valid = 1'b0;
  endtask

  task automatic wait_last();
    int i;
    for (i = 0; i < 5000; i++) begin
      @(negedge bus);
      if (got_q.size() > 0 && got_q[$].last) break;
    end
    if (i == 5000) timed_out("no beat with last");
  endtask

  task automatic fill_count(input int n, input la_pkg::la_data_t base);
    src_q.delete();
    src_last_q.delete();
    for (int i = 0; i < n; i++) begin
      src_q.push_back(base + la_pkg::la_data_t'(i));
      src_last_q.push_back(1'b0);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference models
  ////////////////////////////////////////////////////////////

  // every n+1-th beat, starting at the first
  function automatic void dec_ref(input int n);
    exp_q.delete();
    for (int i = 0; i < src_q.size(); i += n + 1)
      exp_q.push_back('{count: 8'd0, data: src_q[i], last: 1'b0});
  endfunction

  function automatic int trig_ref(input logic [7:0] msk, input logic [7:0] val,
                                  input logic [7:0] pos, input logic [7:0] neg);
    logic [7:0] p;
    logic [7:0] s;
    int hits;
    p = 8'd0;
    hits = 0;
    foreach (src_q[i]) begin
      s = src_q[i];
      if (((s & msk) == (val & msk)) &&
          ((pos | neg) == 8'd0 || ((~p & s & pos) != 0) || ((p & ~s & neg) != 0)))
        hits++;
      p = s;
    end
    return hits;
  endfunction

  function automatic void rle_ref();
    la_pkg::la_data_t d;
    int n;
    exp_q.delete();
    n = 0;
    foreach (src_q[i]) begin
      if (n > 0 && src_q[i] != d) begin
        exp_q.push_back('{count: 8'(n), data: d, last: 1'b0});
        n = 0;
      end
      d = src_q[i];
      n++;
      if (src_last_q[i] || n == 255) begin
        exp_q.push_back('{count: 8'(n), data: d, last: src_last_q[i]});
        n = 0;
      end
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [6:0]  ra [10];
    logic [31:0] rm [10];
    logic [6:0]  un [4];
    logic [31:0] wd;
    logic [31:0] rd;
    int          i;
    int          len;
    la_pkg::la_data_t v;

    ra = '{7'h04, 7'h08, 7'h10, 7'h14, 7'h40,
           7'h44, 7'h48, 7'h4c, 7'h50, 7'h54};
    rm = '{32'h3, 32'hf, 32'hffffffff, 32'hffffffff, 32'hff,
           32'hff, 32'hff, 32'hff, 32'h1ffff, 32'h1};
    un = '{7'h0c, 7'h3c, 7'h58, 7'h5c};
    void'($urandom(32'hc244cbbc));
    mism = 0;
    touts = 0;
    stall_en = 1'b0;
    reset = 1'b1;
    req = '0;
    cts = '0;
    trg_ext = '0;
    in = '0;
    in_valid = 1'b0;
    out_ready = 1'b1;
    repeat (16) @(posedge bus);
    #1;
    reset = 1'b0;

    // register readback
    for (i = 0; i < 10; i++) begin
      wd = $urandom;
      bus_write(ra[i], wd);
      bus_read(ra[i], rd);
      cmp_word(rd, wd & rm[i], $sformatf("readback 0x%02h", ra[i]));
    end
    for (i = 0; i < 4; i++) begin
      bus_read(un[i], rd);
      cmp_word(rd, 32'd0, $sformatf("unmapped 0x%02h", un[i]));
    end

    // software trigger capture, pre 5, pst 8
    setup(0, 1, 5, 8, 0, 0);
    bus_write(la_pkg::reg_ctl, 32'h4);
    // first beat goes in once the FSM has left idle
    @(posedge bus);
    #1;
    fill_count(200, 8'd0);
    fork
      drive_all();
      begin
        for (i = 0; i < 50; i++) begin
          bus_read(la_pkg::reg_sts_pre, rd);
          if (rd == 32'd5) break;
        end
        if (i == 50) timed_out("pre count not reached");
        bus_write(la_pkg::reg_ctl, 32'h2);
        wait_last();
      end
    join
    cmp_word(got_q.size() - trg_mark, 32'd8, "beats after trigger");
    foreach (got_q[k])
      cmp_beat(got_q[k], '{count: 8'd0, data: 8'(k), last: k == got_q.size() - 1}, "capture");
    bus_read(la_pkg::reg_sts_pst, rd);
    cmp_word(rd, 32'd8, "sts_pst");
    bus_read(la_pkg::reg_sts_pre, rd);
    cmp_word(rd, 32'd5, "sts_pre");

    // decimation by 4, auto trigger, post outlasts the input
    setup(2, 0, 0, 1000, 3, 0);
    bus_write(la_pkg::reg_ctl, 32'h4);
    @(posedge bus);
    #1;
    fill_count(120, 8'h40);
    dec_ref(3);
    drive_all();
    // bypass encoder adds one cycle
    repeat (2) @(posedge bus);
    #1;
    cmp_word(got_q.size(), exp_q.size(), "decimated count");
    foreach (exp_q[k])
      if (k < got_q.size()) cmp_beat(got_q[k], exp_q[k], "decimated");

    // comparator and edge trigger, acquisition idle
    bus_write(la_pkg::reg_cmp_msk, 32'h0f);
    bus_write(la_pkg::reg_cmp_val, 32'h05);
    bus_write(la_pkg::reg_edg_pos, 32'h01);
    bus_write(la_pkg::reg_edg_neg, 32'h00);
    setup(0, 0, 0, 0, 0, 0);
    src_q.delete();
    src_last_q.delete();
    for (i = 0; i < 80; i++) begin
      src_q.push_back(8'($urandom_range(0, 15)));
      src_last_q.push_back(1'b0);
    end
    trg_cnt = 0;
    drive_all();
    repeat (2) @(posedge bus);
    #1;
    cmp_word(trg_cnt, trig_ref(8'h0f, 8'h05, 8'h01, 8'h00), "trg_out pulses");

    // run-length encoding with random runs and stalls
    src_q.delete();
    src_last_q.delete();
    v = 8'($urandom);
    for (i = 0; i < 7; i++) begin
      v = v + 8'($urandom_range(1, 200));
      len = $urandom_range(1, 300);
      repeat (len) begin
        src_q.push_back(v);
        src_last_q.push_back(1'b0);
      end
    end
    src_last_q[$] = 1'b1;
    rle_ref();
    setup(2, 0, 0, src_q.size(), 0, 1);
    bus_write(la_pkg::reg_ctl, 32'h4);
    for (i = 0; i < 50; i++) begin
      @(negedge bus);
      if (irq_seen) break;
    end
    if (i == 50) timed_out("no irq_trg");
    @(posedge bus);
    #1;
    stall_en = 1'b1;
    fork
      drive_all();
      wait_last();
    join
    stall_en = 1'b0;
    cmp_word(got_q.size(), exp_q.size(), "encoded pair count");
    foreach (exp_q[k])
      if (k < got_q.size()) cmp_beat(got_q[k], exp_q[k], "encoded");

    // stop control during post
    setup(2, 0, 0, 1000, 0, 0);
    bus_write(la_pkg::reg_ctl, 32'h4);
    fill_count(100, 8'd0);
    len = 0;
    fork
      drive_all();
      begin
        for (i = 0; i < 100; i++) begin
          @(negedge bus);
          if (got_q.size() >= 10) break;
        end
        if (i == 100) timed_out("no output before stop");
        @(posedge bus);
        #1;
        bus_write(la_pkg::reg_ctl, 32'h8);
        repeat (2) @(posedge bus);
        len = got_q.size();
      end
    join
    repeat (3) @(posedge bus);
    #1;
    cmp_word(got_q.size(), len, "beats after stop");
    cmp_word(irqs_cnt, 32'd1, "irq_stp pulses");
    bus_read(la_pkg::reg_ctl, rd);
    cmp_word(rd, 32'ha, "ctl status after stop");

    $display("errors: %0d mismatches, %0d timeouts", mism, touts);
    if (mism + touts == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- build.f
la_pkg.sv
la_regs.sv
str_dec.sv
la_trigger.sv
la_acq.sv
la_rle.sv
la_top.sv
la_assert.sv
tb_la.sv

//--- run.sh
#!/bin/sh
# compile and run with Verilator, verdict from the simulation log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_la -f build.f -o sim_la > build.log 2>&1 \
  && ./obj_dir/sim_la > sim.log 2>&1 \
  || { echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "Simulation FAILED" sim.log && { echo "FAIL"; exit 1; } \
  || { echo "PASS"; exit 0; }
